//--- files.f
cpu_pkg.sv
reg_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
writeback_stage.sv
hazard_unit.sv
cpu_top.sv
tb_cpu.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f files.f --top-module tb_cpu
output="$(./obj_dir/Vtb_cpu)"
echo "$output"
if grep -qx "Done: no errors" <<< "$output"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- tb_cpu.sv
`timescale 1ns/10ps
module tb_cpu;

    localparam logic [31:0] RESET_PC = 32'h1c00_0000;
    localparam int MEM_WORDS   = 256;
    localparam int NUM_TESTS   = 5;
    localparam int CYCLE_LIMIT = NUM_TESTS * 200;

    // loongarch encodings of the instructions under test
    localparam logic [16:0] ADD_W   = 17'h00020;
    localparam logic [16:0] SUB_W   = 17'h00022;
    localparam logic [16:0] SLT_OP  = 17'h00024;
    localparam logic [16:0] SLTU_OP = 17'h00025;
    localparam logic [16:0] AND_OP  = 17'h00029;
    localparam logic [16:0] OR_OP   = 17'h0002a;
    localparam logic [16:0] XOR_OP  = 17'h0002b;
    localparam logic [9:0]  ADDI_W  = 10'h00a;
    localparam logic [9:0]  LD_W    = 10'h0a2;
    localparam logic [9:0]  ST_W    = 10'h0a6;
    localparam logic [6:0]  LU12I_W = 7'h0a;
    localparam logic [5:0]  BEQ_OP  = 6'h16;
    localparam logic [5:0]  BNE_OP  = 6'h17;
    localparam logic [5:0]  B_OP    = 6'h14;

    logic        clk;
    logic        reset_i;
    logic [31:0] inst_addr, data_addr, data_wdata, wb_pc, wb_wdata;
    logic [31:0] inst_rdata = '0;
    logic [31:0] data_rdata = '0;
    logic        data_en, wb_we;
    logic [3:0]  data_we;
    logic [4:0]  wb_wnum;

    logic [31:0] imem [MEM_WORDS];
    logic [31:0] dmem [MEM_WORDS];
    logic [31:0] inst_addr_q, data_addr_q, data_wdata_q;
    logic        data_en_q, reset_q;
    logic [3:0]  data_we_q;
    int          inst_idx, data_idx;

    logic [31:0] prog [$];
    logic [31:0] exp_pc [$], exp_num [$], exp_data [$];
    logic [31:0] got_pc [$], got_num [$], got_data [$];
    int errors = 0;
    int checks = 0;
    int cycles;

    cpu_top #(.RESET_PC(RESET_PC)) uut (
        .clk(clk), .reset_i(reset_i),
        .inst_addr_o(inst_addr), .inst_rdata_i(inst_rdata),
        .data_en_o(data_en), .data_we_o(data_we), .data_addr_o(data_addr),
        .data_wdata_o(data_wdata), .data_rdata_i(data_rdata),
        .debug_wb_pc_o(wb_pc), .debug_wb_we_o(wb_we),
        .debug_wb_wnum_o(wb_wnum), .debug_wb_wdata_o(wb_wdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] three_reg(input logic [16:0] op, input int rd, rj, rk);
        return {op, rk[4:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] reg_imm12(input logic [9:0] op, input int rd, rj, imm);
        return {op, imm[11:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] upper_imm(input int rd, input int si20);
        return {LU12I_W, si20[19:0], rd[4:0]};
    endfunction

    // offsets count words from the branch itself
    function automatic logic [31:0] cond_branch(input logic [5:0] op, input int rj, rd, offs);
        return {op, offs[15:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] uncond_branch(input int offs);
        return {B_OP, offs[15:0], offs[25:16]};
    endfunction

    function automatic int word_index(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - RESET_PC;
        if ($isunknown(addr) || offset >= MEM_WORDS * 4)
            return -1;
        return int'(offset >> 2);
    endfunction

    function automatic logic [31:0] code_fill(input logic [31:0] addr);
        return {8'hff, addr[23:0] ^ {16'h0, addr[31:24]}};   // top byte ff decodes as no-op
    endfunction

    function automatic logic [31:0] data_fill(input logic [31:0] addr);
        return addr ^ 32'h5a5a_5a5a;
    endfunction

    // sram requests are stable here and answered after the next edge
    always @(negedge clk)
    begin
        inst_addr_q  <= inst_addr;
        data_en_q    <= data_en;
        data_we_q    <= data_we;
        data_addr_q  <= data_addr;
        data_wdata_q <= data_wdata;
        reset_q      <= reset_i;
    end

    always @(posedge clk)
    begin
        #1;
        inst_idx = word_index(inst_addr_q);
        if (inst_idx < 0)
            inst_rdata <= code_fill(inst_addr_q);
        else
            inst_rdata <= imem[inst_idx];
        data_idx = word_index(data_addr_q);
        if (reset_q)
        begin
            for (int i = 0; i < MEM_WORDS; i++)
                dmem[i] = data_fill(RESET_PC + 32'(i * 4));
        end
        else if (data_en_q === 1'b1 && data_idx >= 0)
        begin
            if (data_we_q == 4'hf)
                dmem[data_idx] = data_wdata_q;
            else
                data_rdata <= dmem[data_idx];
        end
    end

    // trace collection
    always @(negedge clk)
    begin
        if (reset_i)
        begin
            got_pc.delete();
            got_num.delete();
            got_data.delete();
        end
        else if (wb_we === 1'b1)
        begin
            got_pc.push_back(wb_pc);
            got_num.push_back({27'b0, wb_wnum});
            got_data.push_back(wb_wdata);
        end
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic expect_retire(input int idx, input int rd, input logic [31:0] value);
        exp_pc.push_back(RESET_PC + 32'(idx * 4));
        exp_num.push_back(32'(rd));
        exp_data.push_back(value);
    endtask

    // loads prog under reset, checks the reset state, releases reset
    task automatic start_program();
        @(posedge clk);
        #1;
        reset_i = 1'b1;
        for (int i = 0; i < MEM_WORDS; i++)
            imem[i] = code_fill(RESET_PC + 32'(i * 4));
        for (int i = 0; i < prog.size(); i++)
            imem[i] = prog[i];
        prog.delete();
        repeat (2) @(posedge clk);
        @(negedge clk);
        compare("inst_addr_o", inst_addr, RESET_PC);
        compare("data_en_o", {31'b0, data_en}, 32'd0);
        compare("data_we_o", {28'b0, data_we}, 32'd0);
        compare("debug_wb_we_o", {31'b0, wb_we}, 32'd0);
        @(posedge clk);
        #1;
        reset_i = 1'b0;
    endtask

    task automatic wait_for_trace(input int n);
        while (got_pc.size() < n)
            @(negedge clk);
        repeat (8) @(negedge clk);   // room for any unexpected extra entry
    endtask

    task automatic verify_trace();
        int n;
        compare("trace count", got_pc.size(), exp_pc.size());
        n = (got_pc.size() < exp_pc.size()) ? got_pc.size() : exp_pc.size();
        for (int i = 0; i < n; i++)
        begin
            compare("debug_wb_pc_o", got_pc[i], exp_pc[i]);
            compare("debug_wb_wnum_o", got_num[i], exp_num[i]);
            compare("debug_wb_wdata_o", got_data[i], exp_data[i]);
        end
        exp_pc.delete();
        exp_num.delete();
        exp_data.delete();
    endtask

    task automatic reset_state();
        prog.push_back(reg_imm12(ADDI_W, 1, 0, 5));
        prog.push_back(uncond_branch(0));
        expect_retire(0, 1, 32'd5);
        start_program();
        @(negedge clk);
        compare("inst_addr_o", inst_addr, RESET_PC);
        while (wb_we !== 1'b1)
        begin
            compare("data_en_o", {31'b0, data_en}, 32'd0);
            compare("data_we_o", {28'b0, data_we}, 32'd0);
            @(negedge clk);
        end
        wait_for_trace(exp_pc.size());
        verify_trace();
    endtask

    task automatic alu_chain();
        logic [31:0] v1, v2, v3, v4, v5, v6, v7, v8, v9;
        v1 = 32'h87654 << 12;
        v2 = v1 + 32'h678;
        v3 = v2 + v1;
        v4 = v3 - v2;
        v5 = v4 & v3;
        v6 = v5 | v4;
        v7 = v6 ^ v5;
        v8 = {31'b0, $signed(v7) < $signed(v6)};
        v9 = {31'b0, v8 < v7};
        prog.push_back(upper_imm(1, 'h87654));
        prog.push_back(reg_imm12(ADDI_W, 2, 1, 'h678));
        prog.push_back(three_reg(ADD_W, 3, 2, 1));
        prog.push_back(three_reg(SUB_W, 4, 3, 2));
        prog.push_back(three_reg(AND_OP, 5, 4, 3));
        prog.push_back(three_reg(OR_OP, 6, 5, 4));
        prog.push_back(three_reg(XOR_OP, 7, 6, 5));
        prog.push_back(three_reg(ADD_W, 0, 7, 7));   // r0 write never traced
        prog.push_back(three_reg(SLT_OP, 8, 7, 6));
        prog.push_back(three_reg(SLTU_OP, 9, 8, 7));
        prog.push_back(uncond_branch(0));
        expect_retire(0, 1, v1);
        expect_retire(1, 2, v2);
        expect_retire(2, 3, v3);
        expect_retire(3, 4, v4);
        expect_retire(4, 5, v5);
        expect_retire(5, 6, v6);
        expect_retire(6, 7, v7);
        expect_retire(8, 8, v8);
        expect_retire(9, 9, v9);
        start_program();
        wait_for_trace(exp_pc.size());
        verify_trace();
    endtask

    task automatic load_use();
        logic [31:0] base, word;
        base = 32'h1c000 << 12;
        word = (32'habcde << 12) + 32'h123;
        prog.push_back(upper_imm(1, 'h1c000));
        prog.push_back(upper_imm(2, 'habcde));
        prog.push_back(reg_imm12(ADDI_W, 2, 2, 'h123));
        prog.push_back(reg_imm12(ST_W, 2, 1, 'h200));
        prog.push_back(reg_imm12(LD_W, 3, 1, 'h200));
        prog.push_back(three_reg(ADD_W, 4, 3, 1));   // needs the load result at once
        prog.push_back(uncond_branch(0));
        expect_retire(0, 1, base);
        expect_retire(1, 2, 32'habcde << 12);
        expect_retire(2, 2, word);
        expect_retire(4, 3, word);
        expect_retire(5, 4, word + base);
        start_program();
        wait_for_trace(exp_pc.size());
        verify_trace();
        compare("dmem word at offset 0x200", dmem['h200 >> 2], word);
    endtask

    task automatic branch_paths();
        prog.push_back(reg_imm12(ADDI_W, 1, 0, 7));
        prog.push_back(reg_imm12(ADDI_W, 2, 0, 7));
        prog.push_back(cond_branch(BEQ_OP, 1, 2, 3));   // taken to word 5
        prog.push_back(reg_imm12(ADDI_W, 3, 0, 1));
        prog.push_back(reg_imm12(ADDI_W, 3, 0, 2));
        prog.push_back(cond_branch(BNE_OP, 1, 2, 2));   // falls through
        prog.push_back(reg_imm12(ADDI_W, 4, 0, 9));
        prog.push_back(uncond_branch(3));
        prog.push_back(reg_imm12(ADDI_W, 5, 0, 1));
        prog.push_back(reg_imm12(ADDI_W, 5, 0, 2));
        prog.push_back(reg_imm12(ADDI_W, 6, 4, 1));
        prog.push_back(uncond_branch(0));
        expect_retire(0, 1, 32'd7);
        expect_retire(1, 2, 32'd7);
        expect_retire(6, 4, 32'd9);
        expect_retire(10, 6, 32'd10);
        start_program();
        wait_for_trace(exp_pc.size());
        verify_trace();
    endtask

    task automatic unknown_opcode();
        prog.push_back(reg_imm12(ADDI_W, 1, 0, 'h55));
        prog.push_back(32'h0000_0001);   // matches no opcode yet names r1 as rd
        prog.push_back(reg_imm12(ADDI_W, 2, 1, 1));
        prog.push_back(uncond_branch(0));
        expect_retire(0, 1, 32'h55);
        expect_retire(2, 2, 32'h56);
        start_program();
        wait_for_trace(exp_pc.size());
        verify_trace();
    endtask

    task automatic end_run(input bit timed_out);
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0 && !timed_out)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    endtask

    initial
    begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: tests still running after %0d cycles", CYCLE_LIMIT);
        end_run(1'b1);
    end

    initial
    begin
        reset_i = 1'b1;
        reset_state();
        alu_chain();
        load_use();
        branch_paths();
        unknown_opcode();
        end_run(1'b0);
    end

endmodule

//--- cpu_top.sv
`timescale 1ns/10ps
module cpu_top #(
    parameter cpu_pkg::word_t RESET_PC = 32'h1c00_0000
) (
    input  logic               clk,
    input  logic               reset_i,
    output cpu_pkg::word_t     inst_addr_o,
    input  cpu_pkg::word_t     inst_rdata_i,
    output logic               data_en_o,
    output logic [3:0]         data_we_o,
    output cpu_pkg::word_t     data_addr_o,
    output cpu_pkg::word_t     data_wdata_o,
    input  cpu_pkg::word_t     data_rdata_i,
    output cpu_pkg::word_t     debug_wb_pc_o,
    output logic               debug_wb_we_o,
    output cpu_pkg::reg_addr_t debug_wb_wnum_o,
    output cpu_pkg::word_t     debug_wb_wdata_o
);
    import cpu_pkg::*;

    logic      stall, redirect;
    word_t     redirect_pc;
    logic      id_valid;
    word_t     id_pc, id_instr;
    reg_addr_t id_rs1, id_rs2;
    word_t     ex_pc, ex_a, ex_b, ex_imm;
    reg_addr_t ex_rs1, ex_rs2, ex_rd;
    alu_op_t   ex_alu_op;
    br_op_t    ex_br_op;
    logic      ex_use_imm, ex_reg_we, ex_mem_read, ex_mem_write;
    fwd_sel_t  fwd_a, fwd_b;
    word_t     mem_pc, mem_result;
    reg_addr_t mem_rd;
    logic      mem_reg_we, mem_load;
    logic      wb_we;
    reg_addr_t wb_rd;
    word_t     wb_data;

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .clk, .reset_i, .stall_i(stall), .redirect_i(redirect), .redirect_pc_i(redirect_pc),
        .inst_rdata_i, .inst_addr_o,
        .id_valid_o(id_valid), .id_pc_o(id_pc), .id_instr_o(id_instr)
    );

    decode_stage u_decode (
        .clk, .reset_i, .stall_i(stall), .flush_i(redirect),
        .id_valid_i(id_valid), .id_pc_i(id_pc), .id_instr_i(id_instr),
        .wb_we_i(wb_we), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
        .id_rs1_o(id_rs1), .id_rs2_o(id_rs2),
        .ex_pc_o(ex_pc), .ex_rs1_o(ex_rs1), .ex_rs2_o(ex_rs2), .ex_rd_o(ex_rd),
        .ex_a_o(ex_a), .ex_b_o(ex_b), .ex_imm_o(ex_imm),
        .ex_alu_op_o(ex_alu_op), .ex_br_op_o(ex_br_op), .ex_use_imm_o(ex_use_imm),
        .ex_reg_we_o(ex_reg_we), .ex_mem_read_o(ex_mem_read), .ex_mem_write_o(ex_mem_write)
    );

    execute_stage u_execute (
        .clk, .reset_i,
        .ex_pc_i(ex_pc), .ex_rd_i(ex_rd), .ex_a_i(ex_a), .ex_b_i(ex_b), .ex_imm_i(ex_imm),
        .ex_alu_op_i(ex_alu_op), .ex_br_op_i(ex_br_op), .ex_use_imm_i(ex_use_imm),
        .ex_reg_we_i(ex_reg_we), .ex_mem_read_i(ex_mem_read), .ex_mem_write_i(ex_mem_write),
        .fwd_a_i(fwd_a), .fwd_b_i(fwd_b), .mem_fwd_i(mem_result), .wb_fwd_i(wb_data),
        .redirect_o(redirect), .redirect_pc_o(redirect_pc),
        .data_en_o, .data_we_o, .data_addr_o, .data_wdata_o,
        .mem_pc_o(mem_pc), .mem_rd_o(mem_rd), .mem_result_o(mem_result),
        .mem_reg_we_o(mem_reg_we), .mem_load_o(mem_load)
    );

    writeback_stage u_writeback (
        .clk, .reset_i,
        .mem_pc_i(mem_pc), .mem_rd_i(mem_rd), .mem_result_i(mem_result),
        .mem_reg_we_i(mem_reg_we), .mem_load_i(mem_load), .data_rdata_i,
        .wb_we_o(wb_we), .wb_rd_o(wb_rd), .wb_data_o(wb_data),
        .debug_wb_pc_o, .debug_wb_we_o, .debug_wb_wnum_o, .debug_wb_wdata_o
    );

    hazard_unit u_hazard (
        .id_rs1_i(id_rs1), .id_rs2_i(id_rs2),
        .ex_rs1_i(ex_rs1), .ex_rs2_i(ex_rs2), .ex_rd_i(ex_rd), .ex_load_i(ex_mem_read),
        .mem_rd_i(mem_rd), .mem_we_i(mem_reg_we), .wb_rd_i(wb_rd), .wb_we_i(wb_we),
        .stall_o(stall), .fwd_a_o(fwd_a), .fwd_b_o(fwd_b)
    );

endmodule

//--- hazard_unit.sv
`timescale 1ns/10ps
module hazard_unit (
    input  cpu_pkg::reg_addr_t id_rs1_i,
    input  cpu_pkg::reg_addr_t id_rs2_i,
    input  cpu_pkg::reg_addr_t ex_rs1_i,
    input  cpu_pkg::reg_addr_t ex_rs2_i,
    input  cpu_pkg::reg_addr_t ex_rd_i,
    input  logic               ex_load_i,
    input  cpu_pkg::reg_addr_t mem_rd_i,
    input  logic               mem_we_i,
    input  cpu_pkg::reg_addr_t wb_rd_i,
    input  logic               wb_we_i,
    output logic               stall_o,
    output cpu_pkg::fwd_sel_t  fwd_a_o,
    output cpu_pkg::fwd_sel_t  fwd_b_o
);
    import cpu_pkg::*;

    // memory stage holds the younger value, so it is checked first
    function automatic fwd_sel_t fwd_for(reg_addr_t rs, reg_addr_t m_rd, logic m_we,
                                         reg_addr_t w_rd, logic w_we);
        if (rs == 5'd0)
            fwd_for = FWD_RF;
        else if (m_we && m_rd == rs)
            fwd_for = FWD_MEM;
        else if (w_we && w_rd == rs)
            fwd_for = FWD_WB;
        else
            fwd_for = FWD_RF;
    endfunction

    assign fwd_a_o = fwd_for(ex_rs1_i, mem_rd_i, mem_we_i, wb_rd_i, wb_we_i);
    assign fwd_b_o = fwd_for(ex_rs2_i, mem_rd_i, mem_we_i, wb_rd_i, wb_we_i);

    // load data is only ready from writeback on
    assign stall_o = ex_load_i && (ex_rd_i != 5'd0) &&
                     (ex_rd_i == id_rs1_i || ex_rd_i == id_rs2_i);

endmodule

//--- writeback_stage.sv
`timescale 1ns/10ps
module writeback_stage (
    input  logic               clk,
    input  logic               reset_i,
    input  cpu_pkg::word_t     mem_pc_i,
    input  cpu_pkg::reg_addr_t mem_rd_i,
    input  cpu_pkg::word_t     mem_result_i,
    input  logic               mem_reg_we_i,
    input  logic               mem_load_i,
    input  cpu_pkg::word_t     data_rdata_i,
    output logic               wb_we_o,
    output cpu_pkg::reg_addr_t wb_rd_o,
    output cpu_pkg::word_t     wb_data_o,
    output cpu_pkg::word_t     debug_wb_pc_o,
    output logic               debug_wb_we_o,
    output cpu_pkg::reg_addr_t debug_wb_wnum_o,
    output cpu_pkg::word_t     debug_wb_wdata_o
);
    import cpu_pkg::*;

    word_t pc_q, result_q, rdata_q;
    logic  load_q;

    always_ff @(posedge clk)
    begin
        if (reset_i)
            wb_we_o <= 1'b0;
        else
            wb_we_o <= mem_reg_we_i;
    end

    always_ff @(posedge clk)
    begin
        pc_q     <= mem_pc_i;
        wb_rd_o  <= mem_rd_i;
        result_q <= mem_result_i;
        rdata_q  <= data_rdata_i;   // sram answers during the memory cycle
        load_q   <= mem_load_i;
    end

    assign wb_data_o = load_q ? rdata_q : result_q;

    // trace of the retiring write
    assign debug_wb_pc_o    = pc_q;
    assign debug_wb_we_o    = wb_we_o;
    assign debug_wb_wnum_o  = wb_rd_o;
    assign debug_wb_wdata_o = wb_data_o;

endmodule

//--- execute_stage.sv
`timescale 1ns/10ps
module execute_stage (
    input  logic               clk,
    input  logic               reset_i,
    input  cpu_pkg::word_t     ex_pc_i,
    input  cpu_pkg::reg_addr_t ex_rd_i,
    input  cpu_pkg::word_t     ex_a_i,
    input  cpu_pkg::word_t     ex_b_i,
    input  cpu_pkg::word_t     ex_imm_i,
    input  cpu_pkg::alu_op_t   ex_alu_op_i,
    input  cpu_pkg::br_op_t    ex_br_op_i,
    input  logic               ex_use_imm_i,
    input  logic               ex_reg_we_i,
    input  logic               ex_mem_read_i,
    input  logic               ex_mem_write_i,
    input  cpu_pkg::fwd_sel_t  fwd_a_i,
    input  cpu_pkg::fwd_sel_t  fwd_b_i,
    input  cpu_pkg::word_t     mem_fwd_i,
    input  cpu_pkg::word_t     wb_fwd_i,
    output logic               redirect_o,
    output cpu_pkg::word_t     redirect_pc_o,
    output logic               data_en_o,
    output logic [3:0]         data_we_o,
    output cpu_pkg::word_t     data_addr_o,
    output cpu_pkg::word_t     data_wdata_o,
    output cpu_pkg::word_t     mem_pc_o,
    output cpu_pkg::reg_addr_t mem_rd_o,
    output cpu_pkg::word_t     mem_result_o,
    output logic               mem_reg_we_o,
    output logic               mem_load_o
);
    import cpu_pkg::*;

    word_t op_a, op_b, alu_b, alu_res;

    function automatic word_t pick(fwd_sel_t sel, word_t rf, word_t mem, word_t wb);
        case (sel)
            FWD_MEM: pick = mem;
            FWD_WB:  pick = wb;
            default: pick = rf;   // FWD_RF
        endcase
    endfunction

    assign op_a  = pick(fwd_a_i, ex_a_i, mem_fwd_i, wb_fwd_i);
    assign op_b  = pick(fwd_b_i, ex_b_i, mem_fwd_i, wb_fwd_i);
    assign alu_b = ex_use_imm_i ? ex_imm_i : op_b;

    always_comb
    begin
        case (ex_alu_op_i)
            ALU_SUB:  alu_res = op_a - alu_b;
            ALU_AND:  alu_res = op_a & alu_b;
            ALU_OR:   alu_res = op_a | alu_b;
            ALU_XOR:  alu_res = op_a ^ alu_b;
            ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(alu_b)};
            ALU_SLTU: alu_res = {31'b0, op_a < alu_b};
            ALU_LUI:  alu_res = alu_b;
            default:  alu_res = op_a + alu_b;   // add, addi and addresses
        endcase
    end

    // branches compare rj with rd
    always_comb
    begin
        case (ex_br_op_i)
            BR_EQ:     redirect_o = (op_a == op_b);
            BR_NE:     redirect_o = (op_a != op_b);
            BR_ALWAYS: redirect_o = 1'b1;
            default:   redirect_o = 1'b0;
        endcase
    end
    assign redirect_pc_o = ex_pc_i + ex_imm_i;

    assign data_en_o    = ex_mem_read_i || ex_mem_write_i;
    assign data_we_o    = {4{ex_mem_write_i}};
    assign data_addr_o  = alu_res;
    assign data_wdata_o = op_b;

    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            mem_reg_we_o <= 1'b0;
            mem_load_o   <= 1'b0;
        end
        else
        begin
            mem_reg_we_o <= ex_reg_we_i;
            mem_load_o   <= ex_mem_read_i;
        end
    end

    always_ff @(posedge clk)
    begin
        mem_pc_o     <= ex_pc_i;
        mem_rd_o     <= ex_rd_i;
        mem_result_o <= alu_res;
    end

endmodule

//--- decode_stage.sv
`timescale 1ns/10ps
module decode_stage (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               stall_i,
    input  logic               flush_i,
    input  logic               id_valid_i,
    input  cpu_pkg::word_t     id_pc_i,
    input  cpu_pkg::word_t     id_instr_i,
    input  logic               wb_we_i,
    input  cpu_pkg::reg_addr_t wb_rd_i,
    input  cpu_pkg::word_t     wb_data_i,
    output cpu_pkg::reg_addr_t id_rs1_o,
    output cpu_pkg::reg_addr_t id_rs2_o,
    output cpu_pkg::word_t     ex_pc_o,
    output cpu_pkg::reg_addr_t ex_rs1_o,
    output cpu_pkg::reg_addr_t ex_rs2_o,
    output cpu_pkg::reg_addr_t ex_rd_o,
    output cpu_pkg::word_t     ex_a_o,
    output cpu_pkg::word_t     ex_b_o,
    output cpu_pkg::word_t     ex_imm_o,
    output cpu_pkg::alu_op_t   ex_alu_op_o,
    output cpu_pkg::br_op_t    ex_br_op_o,
    output logic               ex_use_imm_o,
    output logic               ex_reg_we_o,
    output logic               ex_mem_read_o,
    output logic               ex_mem_write_o
);
    import cpu_pkg::*;

    word_t     rdata1, rdata2, imm;
    reg_addr_t rd;
    alu_op_t   alu_op, op_3r;
    br_op_t    br_op;
    logic      is_3r, use_imm, reg_we, mem_read, mem_write, rd_is_src;
    logic      bubble;

    assign rd       = id_instr_i[4:0];
    assign id_rs1_o = id_instr_i[9:5];                          // rj
    assign id_rs2_o = rd_is_src ? rd : id_instr_i[14:10];       // rk, or rd for st/branch
    assign bubble   = stall_i || flush_i || !id_valid_i;

    reg_file u_rf (
        .clk, .reset_i,
        .raddr1_i(id_rs1_o), .raddr2_i(id_rs2_o),
        .rdata1_o(rdata1), .rdata2_o(rdata2),
        .we_i(wb_we_i), .waddr_i(wb_rd_i), .wdata_i(wb_data_i)
    );

    // 3R group differs only in the alu operation
    always_comb
    begin
        is_3r = 1'b1;
        op_3r = ALU_ADD;
        case (id_instr_i[31:15])
            OP17_ADD_W: op_3r = ALU_ADD;
            OP17_SUB_W: op_3r = ALU_SUB;
            OP17_AND:   op_3r = ALU_AND;
            OP17_OR:    op_3r = ALU_OR;
            OP17_XOR:   op_3r = ALU_XOR;
            OP17_SLT:   op_3r = ALU_SLT;
            OP17_SLTU:  op_3r = ALU_SLTU;
            default:    is_3r = 1'b0;
        endcase
    end

    always_comb
    begin
        alu_op    = op_3r;
        br_op     = BR_NONE;
        use_imm   = 1'b0;
        reg_we    = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        rd_is_src = 1'b0;
        imm       = {{20{id_instr_i[21]}}, id_instr_i[21:10]};   // si12
        if (is_3r)
            reg_we = 1'b1;
        else if (id_instr_i[31:22] == OP10_ADDI_W || id_instr_i[31:22] == OP10_LD_W)
        begin
            alu_op   = ALU_ADD;
            use_imm  = 1'b1;
            reg_we   = 1'b1;
            mem_read = (id_instr_i[31:22] == OP10_LD_W);
        end
        else if (id_instr_i[31:22] == OP10_ST_W)
        begin
            alu_op    = ALU_ADD;   // address
            use_imm   = 1'b1;
            mem_write = 1'b1;
            rd_is_src = 1'b1;
        end
        else if (id_instr_i[31:25] == OP7_LU12I_W)
        begin
            alu_op  = ALU_LUI;
            use_imm = 1'b1;
            reg_we  = 1'b1;
            imm     = {id_instr_i[24:5], 12'b0};
        end
        else if (id_instr_i[31:26] == OP6_BEQ || id_instr_i[31:26] == OP6_BNE)
        begin
            br_op     = (id_instr_i[31:26] == OP6_BEQ) ? BR_EQ : BR_NE;
            rd_is_src = 1'b1;
            imm       = {{14{id_instr_i[25]}}, id_instr_i[25:10], 2'b00};
        end
        else if (id_instr_i[31:26] == OP6_B)
        begin
            br_op = BR_ALWAYS;
            imm   = {{4{id_instr_i[9]}}, id_instr_i[9:0], id_instr_i[25:10], 2'b00};
        end
        // anything else stays a no-op
    end

    always_ff @(posedge clk)
    begin
        if (reset_i || bubble)
        begin
            ex_br_op_o     <= BR_NONE;
            ex_reg_we_o    <= 1'b0;
            ex_mem_read_o  <= 1'b0;
            ex_mem_write_o <= 1'b0;
        end
        else
        begin
            ex_br_op_o     <= br_op;
            ex_reg_we_o    <= reg_we && (rd != 5'd0);   // r0 writes end here
            ex_mem_read_o  <= mem_read;
            ex_mem_write_o <= mem_write;
        end
    end

    always_ff @(posedge clk)
    begin
        ex_pc_o      <= id_pc_i;
        ex_rs1_o     <= id_rs1_o;
        ex_rs2_o     <= id_rs2_o;
        ex_rd_o      <= rd;
        ex_a_o       <= rdata1;
        ex_b_o       <= rdata2;
        ex_imm_o     <= imm;
        ex_alu_op_o  <= alu_op;
        ex_use_imm_o <= use_imm;
    end

endmodule

//--- fetch_stage.sv
`timescale 1ns/10ps
module fetch_stage #(
    parameter cpu_pkg::word_t RESET_PC = 32'h1c00_0000
) (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           stall_i,
    input  logic           redirect_i,
    input  cpu_pkg::word_t redirect_pc_i,
    input  cpu_pkg::word_t inst_rdata_i,
    output cpu_pkg::word_t inst_addr_o,
    output logic           id_valid_o,
    output cpu_pkg::word_t id_pc_o,
    output cpu_pkg::word_t id_instr_o
);
    import cpu_pkg::*;

    word_t pc_q;        // address whose word returns this cycle
    logic  pc_valid_q;  // low until the first real fetch is in flight

    always_comb
    begin
        if (redirect_i)
            inst_addr_o = redirect_pc_i;
        else if (stall_i)
            inst_addr_o = pc_q;   // ask for the same word again
        else
            inst_addr_o = pc_q + 32'd4;
    end

    // one below the reset address, so the first issue is RESET_PC
    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            pc_q       <= RESET_PC - 32'd4;
            pc_valid_q <= 1'b0;
        end
        else
        begin
            pc_q       <= inst_addr_o;
            pc_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset_i || redirect_i)
            id_valid_o <= 1'b0;   // drops the word now returning
        else if (!stall_i)
            id_valid_o <= pc_valid_q;
    end

    always_ff @(posedge clk)
    begin
        if (!stall_i)
        begin
            id_pc_o    <= pc_q;
            id_instr_o <= inst_rdata_i;
        end
    end

endmodule

//--- reg_file.sv
`timescale 1ns/10ps
module reg_file (
    input  logic               clk,
    input  logic               reset_i,
    input  cpu_pkg::reg_addr_t raddr1_i,
    input  cpu_pkg::reg_addr_t raddr2_i,
    output cpu_pkg::word_t     rdata1_o,
    output cpu_pkg::word_t     rdata2_o,
    input  logic               we_i,
    input  cpu_pkg::reg_addr_t waddr_i,
    input  cpu_pkg::word_t     wdata_i
);
    import cpu_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (we_i && waddr_i != 5'd0)
            regs[waddr_i] <= wdata_i;
    end

    // writeback value bypasses the array in the same cycle
    assign rdata1_o = (raddr1_i == 5'd0) ? '0 :
                      (we_i && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == 5'd0) ? '0 :
                      (we_i && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  br_op_t;
    typedef logic [1:0]  fwd_sel_t;

    // alu operations
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_AND  = 4'd2;
    localparam alu_op_t ALU_OR   = 4'd3;
    localparam alu_op_t ALU_XOR  = 4'd4;
    localparam alu_op_t ALU_SLT  = 4'd5;
    localparam alu_op_t ALU_SLTU = 4'd6;
    localparam alu_op_t ALU_LUI  = 4'd7;   // passes operand b

    localparam br_op_t BR_NONE   = 2'd0;
    localparam br_op_t BR_EQ     = 2'd1;
    localparam br_op_t BR_NE     = 2'd2;
    localparam br_op_t BR_ALWAYS = 2'd3;

    // operand source in execute
    localparam fwd_sel_t FWD_RF  = 2'd0;
    localparam fwd_sel_t FWD_MEM = 2'd1;
    localparam fwd_sel_t FWD_WB  = 2'd2;

    // 3R group, instr[31:15]
    localparam logic [16:0] OP17_ADD_W = 17'h00020;
    localparam logic [16:0] OP17_SUB_W = 17'h00022;
    localparam logic [16:0] OP17_SLT   = 17'h00024;
    localparam logic [16:0] OP17_SLTU  = 17'h00025;
    localparam logic [16:0] OP17_AND   = 17'h00029;
    localparam logic [16:0] OP17_OR    = 17'h0002a;
    localparam logic [16:0] OP17_XOR   = 17'h0002b;

    localparam logic [9:0] OP10_ADDI_W = 10'h00a;   // instr[31:22]
    localparam logic [9:0] OP10_LD_W   = 10'h0a2;
    localparam logic [9:0] OP10_ST_W   = 10'h0a6;
    localparam logic [6:0] OP7_LU12I_W = 7'h0a;     // instr[31:25]
    localparam logic [5:0] OP6_BEQ     = 6'h16;     // instr[31:26]
    localparam logic [5:0] OP6_BNE     = 6'h17;
    localparam logic [5:0] OP6_B       = 6'h14;

endpackage
